// ==== logic/druaga_bus_config.svh ====
/* Bus core sizing: CPU bus widths, RAM depths
   and the size of the player input window */
`ifndef DRUAGA_BUS_CONFIG_SVH
`define DRUAGA_BUS_CONFIG_SVH

// CPU side
`define BUS_ADDR_W 16
`define BUS_DATA_W 8

// Main CPU ROM port, $8000-$FFFF
`define ROM_ADDR_W 15

// One video bank, 2 K bytes
`define VRAM_ADDR_W 11

// Shared RAM, 1 K bytes
`define SHARE_ADDR_W 10

// INP0, INP1, INP2, DSW0, DSW1, DSW2
`define INP_WIN_BYTES 6

`endif

// ==== logic/druaga_bus_pkg.sv ====
/* Bus core types: CPU address views, bus command,
   control latch state and video read request */
`include "druaga_bus_config.svh"

package druaga_bus_pkg;

	// Latch write encoding, value and index ride in the address
	typedef struct packed {
		logic [11:0] region; // Selects the latch block
		logic [2:0]  index;  // Which latch
		logic        value;  // New latch value
	} ctrl_addr_t;

	// Raw view for the map decoders, ctl view for the latches
	typedef union packed {
		logic [`BUS_ADDR_W-1:0] raw;
		ctrl_addr_t             ctl;
	} bus_addr_u;

	// One CPU access
	typedef struct packed {
		bus_addr_u              addr;
		logic                   we;    // High for a write
		logic [`BUS_DATA_W-1:0] wdata;
	} bus_cmd_t;

	// Latch outputs
	typedef struct packed {
		logic [7:0] scroll;     // BG scroll
		logic       main_irq_en;
		logic       sub_irq_en;
		logic       sub_rst_rel; // Sub CPU runs when set
		logic       snd_en;
	} ctrl_state_t;

	// Video side read of both banks
	typedef struct packed {
		logic [`VRAM_ADDR_W-1:0] addr;
	} video_rd_t;

endpackage

// ==== logic/bus_port.sv ====
/* Four-phase req/ack slave, one access strobe per cycle
   and a held read return */
`timescale 1ns/1ns

module bus_port
	import druaga_bus_pkg::*;
(
	input  logic       MCLK,
	input  logic       RESET,
	input  logic       req,
	output logic       ack,
	input  bus_cmd_t   cmd,
	output logic       access,
	input  logic [7:0] rd_in,
	output logic [7:0] rdata
);

	typedef enum logic [1:0] {
		s_idle,
		s_capture,
		s_acked,
		s_release
	} port_state_t;

	port_state_t state;

	// Strobe in the cycle req is first seen, writes commit on that edge
	assign access = (state == s_idle) && req;

	always_ff @(posedge MCLK) begin
		if (RESET) begin
			state <= s_idle;
			ack   <= 1'b0;
		end else begin
			ack <= (state == s_acked); // Two edges after req seen
			case (state)
				s_idle: begin
					if (req)
						state <= s_capture;
				end
				s_capture: state <= s_acked;
				s_acked: begin
					if (!req)
						state <= s_release; // Master done
				end
				default: state <= s_idle; // ack drops here
			endcase
		end
	end

	// Sync RAM output is valid one edge after the strobe
	always_ff @(posedge MCLK) begin
		if (state == s_capture && !cmd.we)
			rdata <= rd_in;
	end

endmodule

// ==== logic/main_map_decode.sv ====
/* Main CPU memory map: video banks, shared RAM, input window,
   ROM and control latch strobe */
`timescale 1ns/1ns
`include "druaga_bus_config.svh"

module main_map_decode
	import druaga_bus_pkg::*;
(
	input  bus_cmd_t                cmd,
	input  logic                    access,
	output logic                    vram_lo_we,
	output logic                    vram_hi_we,
	output logic                    share_we,
	output logic [`ROM_ADDR_W-1:0]  rom_addr,
	input  logic [7:0]              rom_data,
	input  logic [7:0]              vram_lo_q,
	input  logic [7:0]              vram_hi_q,
	input  logic [7:0]              share_q,
	input  logic [47:0]             inputs,
	output logic [7:0]              rd_data,
	output logic                    ctrl_we
);

	logic [15:0] a;
	logic        cs_vlo;
	logic        cs_vhi;
	logic        cs_scroll;
	logic        cs_share;
	logic        cs_inp;
	logic        cs_latch;
	logic        cs_rom;
	logic        wr;
	logic [7:0]  inp_byte;

	assign a = cmd.addr.raw;

	assign cs_vlo    = (a[15:11] == 5'b00000);  // $0000-$07FF
	assign cs_vhi    = (a[15:11] == 5'b00001);  // $0800-$0FFF
	assign cs_scroll = (a[15:11] == 5'b00111);  // $3800-$3FFF
	assign cs_share  = (a[15:10] == 6'b010000); // $4000-$43FF
	assign cs_inp    = (a[15:11] == 5'b01001);  // $4800-$4FFF
	assign cs_latch  = (a[15:4] == 12'h500);    // $5000-$500F
	assign cs_rom    = a[15];                   // $8000-$FFFF

	assign wr = access && cmd.we;

	assign vram_lo_we = wr && cs_vlo;
	assign vram_hi_we = wr && cs_vhi;
	assign share_we   = wr && cs_share;
	assign ctrl_we    = wr && (cs_scroll || cs_latch);

	assign rom_addr = a[`ROM_ADDR_W-1:0];

	// Switch and DIP bytes at the bottom of the window
	always_comb begin
		inp_byte = 8'h00;
		if (a[10:3] == 8'h00 && a[2:0] < `INP_WIN_BYTES)
			inp_byte = inputs[{a[2:0], 3'b000} +: 8];
	end

	// Earlier region wins
	always_comb begin
		if (cs_vlo)
			rd_data = vram_lo_q;
		else if (cs_vhi)
			rd_data = vram_hi_q;
		else if (cs_share)
			rd_data = share_q;
		else if (cs_inp)
			rd_data = inp_byte;
		else if (cs_rom)
			rd_data = rom_data;
		else
			rd_data = 8'h00; // Unmapped
	end

endmodule

// ==== logic/sub_map_decode.sv ====
/* Sub CPU memory map: shared RAM, sound register strobe
   and control latch strobe */
`timescale 1ns/1ns

module sub_map_decode
	import druaga_bus_pkg::*;
(
	input  bus_cmd_t    cmd,
	input  logic        access,
	output logic        share_we,
	input  logic [7:0]  share_q,
	output logic        sound_we,
	output logic [5:0]  sound_addr,
	output logic [7:0]  sound_data,
	output logic        ctrl_we,
	output logic [7:0]  rd_data
);

	logic [15:0] a;
	logic        cs_sreg;
	logic        cs_latch;
	logic        cs_rom;
	logic        cs_share;
	logic        wr;

	assign a = cmd.addr.raw;

	// Sound registers repeat through the low 8 K
	assign cs_sreg  = (a[15:13] == 3'b000) && (a[9:6] == 4'b0000);
	assign cs_latch = (a[15:4] == 12'h200); // $2000-$200F
	assign cs_rom   = (a[15:13] == 3'b111); // $E000-$FFFF, no ROM here
	assign cs_share = !cs_sreg && !cs_latch && !cs_rom;

	assign wr = access && cmd.we;

	assign share_we = wr && cs_share;
	assign ctrl_we  = wr && cs_latch;

	assign sound_we   = wr && cs_sreg;
	assign sound_addr = a[5:0];
	assign sound_data = cmd.wdata;

	assign rd_data = cs_share ? share_q : 8'h00;

endmodule

// ==== logic/dual_port_ram.sv ====
/* Dual-port byte RAM, registered read and write on both sides */
`timescale 1ns/1ns
`include "druaga_bus_config.svh"

module dual_port_ram #(
	parameter int ADDR_W = 10
) (
	input  logic                    MCLK,
	input  logic [ADDR_W-1:0]       a_addr,
	input  logic                    a_we,
	input  logic [`BUS_DATA_W-1:0]  a_d,
	output logic [`BUS_DATA_W-1:0]  a_q,
	input  logic [ADDR_W-1:0]       b_addr,
	input  logic                    b_we,
	input  logic [`BUS_DATA_W-1:0]  b_d,
	output logic [`BUS_DATA_W-1:0]  b_q
);

	logic [`BUS_DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];

	always_ff @(posedge MCLK) begin
		if (a_we)
			mem[a_addr] <= a_d;
		if (b_we)
			mem[b_addr] <= b_d; // Same address on both sides is undefined
	end

	// Write-first on each side
	always_ff @(posedge MCLK) begin
		a_q <= a_we ? a_d : mem[a_addr];
	end

	always_ff @(posedge MCLK) begin
		b_q <= b_we ? b_d : mem[b_addr];
	end

endmodule

// ==== logic/ctrl_regs.sv ====
/* Scroll and control latches, loaded by both CPUs
   with the value carried in the address */
`timescale 1ns/1ns

module ctrl_regs
	import druaga_bus_pkg::*;
(
	input  logic        MCLK,
	input  logic        RESET,
	input  logic        vblank,
	input  logic        main_we,
	input  bus_addr_u   main_addr,
	input  logic        sub_we,
	input  bus_addr_u   sub_addr,
	output ctrl_state_t ctrl,
	output logic        main_irq,
	output logic        sub_irq
);

	logic main_scroll;
	logic main_latch;
	logic sub_latch;

	assign main_scroll = main_we && (main_addr.raw[15:11] == 5'b00111);
	assign main_latch  = main_we && (main_addr.ctl.region == 12'h500);
	assign sub_latch   = sub_we && (sub_addr.ctl.region == 12'h200);

	always_ff @(posedge MCLK) begin
		if (RESET) begin
			ctrl <= '0; // Sub CPU held in reset
		end else begin
			if (main_scroll)
				ctrl.scroll <= main_addr.raw[10:3];

			if (main_latch) begin
				case (main_addr.ctl.index)
					3'd0: ctrl.sub_irq_en  <= main_addr.ctl.value;
					3'd1: ctrl.main_irq_en <= main_addr.ctl.value;
					3'd3: ctrl.snd_en      <= main_addr.ctl.value;
					3'd5: ctrl.sub_rst_rel <= main_addr.ctl.value;
					default: ;
				endcase
			end

			// Sub CPU comes last so it wins a same-cycle clash
			if (sub_latch) begin
				case (sub_addr.ctl.index)
					3'd0: ctrl.sub_irq_en  <= sub_addr.ctl.value;
					3'd3: ctrl.snd_en      <= sub_addr.ctl.value;
					3'd5: ctrl.sub_rst_rel <= sub_addr.ctl.value;
					default: ; // No access to the main IRQ enable
				endcase
			end
		end
	end

	assign main_irq = ctrl.main_irq_en && vblank;
	assign sub_irq  = ctrl.sub_irq_en && vblank;

endmodule

// ==== logic/druaga_bus_core.sv ====
/* CPU-side bus core: both CPU ports, their map decoders,
   video and shared RAM and the control latches */
`timescale 1ns/1ns
`include "druaga_bus_config.svh"

module druaga_bus_core
	import druaga_bus_pkg::*;
(
	input  logic                   MCLK,
	input  logic                   RESET,
	input  logic                   main_req,
	output logic                   main_ack,
	input  bus_cmd_t               main_cmd,
	output logic [7:0]             main_rdata,
	input  logic                   sub_req,
	output logic                   sub_ack,
	input  bus_cmd_t               sub_cmd,
	output logic [7:0]             sub_rdata,
	output logic [`ROM_ADDR_W-1:0] rom_addr,
	input  logic [7:0]             rom_data,
	input  logic [47:0]            inputs,
	input  logic                   vblank,
	input  video_rd_t              video_rd,
	output logic [15:0]            video_data,
	output ctrl_state_t            ctrl,
	output logic                   main_irq,
	output logic                   sub_irq,
	output logic                   sub_cpu_reset,
	output logic                   sound_we,
	output logic [5:0]             sound_addr,
	output logic [7:0]             sound_data
);

	logic       main_access, sub_access;
	logic [7:0] main_rd, sub_rd;
	logic       vram_lo_we, vram_hi_we;
	logic       main_share_we, sub_share_we;
	logic [7:0] vram_lo_q, vram_hi_q;
	logic [7:0] main_share_q, sub_share_q;
	logic       main_ctrl_we, sub_ctrl_we;

	bus_port main_port (
		.MCLK(MCLK), .RESET(RESET), .req(main_req), .ack(main_ack), .cmd(main_cmd),
		.access(main_access), .rd_in(main_rd), .rdata(main_rdata)
	);

	bus_port sub_port (
		.MCLK(MCLK), .RESET(RESET), .req(sub_req), .ack(sub_ack), .cmd(sub_cmd),
		.access(sub_access), .rd_in(sub_rd), .rdata(sub_rdata)
	);

	main_map_decode main_map (
		.cmd(main_cmd), .access(main_access), .vram_lo_we(vram_lo_we),
		.vram_hi_we(vram_hi_we), .share_we(main_share_we), .rom_addr(rom_addr),
		.rom_data(rom_data), .vram_lo_q(vram_lo_q), .vram_hi_q(vram_hi_q),
		.share_q(main_share_q), .inputs(inputs), .rd_data(main_rd), .ctrl_we(main_ctrl_we)
	);

	sub_map_decode sub_map (
		.cmd(sub_cmd), .access(sub_access), .share_we(sub_share_we), .share_q(sub_share_q),
		.sound_we(sound_we), .sound_addr(sound_addr), .sound_data(sound_data),
		.ctrl_we(sub_ctrl_we), .rd_data(sub_rd)
	);

	// Video banks, side B read only by the video side
	dual_port_ram #(.ADDR_W(`VRAM_ADDR_W)) vram_lo (
		.MCLK(MCLK), .a_addr(main_cmd.addr.raw[`VRAM_ADDR_W-1:0]), .a_we(vram_lo_we),
		.a_d(main_cmd.wdata), .a_q(vram_lo_q), .b_addr(video_rd.addr), .b_we(1'b0),
		.b_d(8'h00), .b_q(video_data[7:0])
	);

	dual_port_ram #(.ADDR_W(`VRAM_ADDR_W)) vram_hi (
		.MCLK(MCLK), .a_addr(main_cmd.addr.raw[`VRAM_ADDR_W-1:0]), .a_we(vram_hi_we),
		.a_d(main_cmd.wdata), .a_q(vram_hi_q), .b_addr(video_rd.addr), .b_we(1'b0),
		.b_d(8'h00), .b_q(video_data[15:8])
	);

	dual_port_ram #(.ADDR_W(`SHARE_ADDR_W)) share_ram (
		.MCLK(MCLK), .a_addr(main_cmd.addr.raw[`SHARE_ADDR_W-1:0]), .a_we(main_share_we),
		.a_d(main_cmd.wdata), .a_q(main_share_q),
		.b_addr(sub_cmd.addr.raw[`SHARE_ADDR_W-1:0]), .b_we(sub_share_we),
		.b_d(sub_cmd.wdata), .b_q(sub_share_q)
	);

	ctrl_regs regs (
		.MCLK(MCLK), .RESET(RESET), .vblank(vblank),
		.main_we(main_ctrl_we), .main_addr(main_cmd.addr),
		.sub_we(sub_ctrl_we), .sub_addr(sub_cmd.addr),
		.ctrl(ctrl), .main_irq(main_irq), .sub_irq(sub_irq)
	);

	assign sub_cpu_reset = ~ctrl.sub_rst_rel;

endmodule

// ==== testbench/druaga_bus_chk.sv ====
/* Handshake and reset checks for the bus core,
   bound into druaga_bus_core */
`timescale 1ns/1ns

module druaga_bus_chk (
	input logic MCLK,
	input logic RESET,
	input logic main_req,
	input logic main_ack,
	input logic sub_req,
	input logic sub_ack,
	input logic sub_cpu_reset
);

	int fail_cnt = 0;

	// ack may only be raised at an edge where req is still held
	main_ack_rise: assert property (@(posedge MCLK) disable iff (RESET)
		$rose(main_ack) |-> $past(main_req))
		else begin
			$error("main ack rose without req");
			fail_cnt++;
		end

	sub_ack_rise: assert property (@(posedge MCLK) disable iff (RESET)
		$rose(sub_ack) |-> $past(sub_req))
		else begin
			$error("sub ack rose without req");
			fail_cnt++;
		end

	main_ack_hold: assert property (@(posedge MCLK) disable iff (RESET)
		main_ack && main_req |=> main_ack)
		else begin
			$error("main ack dropped while req high");
			fail_cnt++;
		end

	sub_ack_hold: assert property (@(posedge MCLK) disable iff (RESET)
		sub_ack && sub_req |=> sub_ack)
		else begin
			$error("sub ack dropped while req high");
			fail_cnt++;
		end

	// Sub CPU held after reset
	sub_held: assert property (@(posedge MCLK) RESET |=> sub_cpu_reset)
		else begin
			$error("sub CPU not held in reset");
			fail_cnt++;
		end

endmodule

bind druaga_bus_core druaga_bus_chk chk (
	.MCLK(MCLK),
	.RESET(RESET),
	.main_req(main_req),
	.main_ack(main_ack),
	.sub_req(sub_req),
	.sub_ack(sub_ack),
	.sub_cpu_reset(sub_cpu_reset)
);

// ==== testbench/tb_druaga_bus.sv ====
/* Bus core testbench with both CPUs as bus masters
   and a table of accesses with expected read data and latch state */
`timescale 1ns/1ns
`include "druaga_bus_config.svh"

module tb_druaga_bus
	import druaga_bus_pkg::*;
();

	localparam int   ACK_TIMEOUT = 20; // Cycles
	localparam logic MAIN = 1'b0;
	localparam logic SUB = 1'b1;

	typedef struct packed {
		logic        side;
		bus_cmd_t    cmd;
		logic [7:0]  exp_rd;   // Only for reads
		ctrl_state_t exp_ctrl; // Latch state after the access
	} entry_t;

	logic                   MCLK;
	logic                   RESET;
	logic                   main_req, main_ack, sub_req, sub_ack;
	bus_cmd_t               main_cmd, sub_cmd;
	logic [7:0]             main_rdata, sub_rdata;
	logic [`ROM_ADDR_W-1:0] rom_addr;
	logic [7:0]             rom_data;
	logic [47:0]            inputs;
	logic                   vblank;
	video_rd_t              video_rd;
	logic [15:0]            video_data;
	ctrl_state_t            ctrl;
	logic                   main_irq, sub_irq, sub_cpu_reset;
	logic                   sound_we;
	logic [5:0]             sound_addr;
	logic [7:0]             sound_data;

	entry_t      table_q[$];
	ctrl_state_t exp_c;
	int          snd_pulses = 0;
	logic [5:0]  snd_addr_seen;
	logic [7:0]  snd_data_seen;

	druaga_bus_core uut (.*);

	initial begin
		MCLK = 1'b0;
		forever #4 MCLK = ~MCLK;
	end

	// ROM model returns low byte XOR high byte of the ROM address
	function automatic logic [7:0] rom_byte(input logic [`ROM_ADDR_W-1:0] a);
		return a[7:0] ^ {1'b0, a[`ROM_ADDR_W-1:8]};
	endfunction

	assign rom_data = rom_byte(rom_addr);

	always @(posedge MCLK) begin
		if (!RESET && sound_we) begin
			snd_pulses++;
			snd_addr_seen = sound_addr;
			snd_data_seen = sound_data;
		end
	end

	task automatic stop_run();
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at %0t ns", $time);
	endtask

	always @(uut.chk.fail_cnt) begin
		if (uut.chk.fail_cnt != 0) begin
			$display("A bus handshake or reset assertion failed");
			stop_run();
		end
	end

	task automatic expect_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s returned %02h, expected %02h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic match_ctrl(input ctrl_state_t got, input ctrl_state_t exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s ctrl %03h, expected %03h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic video_word_check(input logic [15:0] got, input logic [15:0] exp,
			input logic [`VRAM_ADDR_W-1:0] a);
		if (got !== exp) begin
			$display("** Error at %0t ns: video word at %03h is %04h, expected %04h",
				$time, a, got, exp);
			stop_run();
		end
	endtask

	task automatic sound_pulse_check(input int count, input logic [5:0] a, input logic [7:0] d,
			input int exp_count, input logic [5:0] exp_a, input logic [7:0] exp_d);
		if (count != exp_count || a !== exp_a || d !== exp_d) begin
			$display("** Error at %0t ns: sound %0d pulses %02h/%02h, expected %0d %02h/%02h",
				$time, count, a, d, exp_count, exp_a, exp_d);
			stop_run();
		end
	endtask

	task automatic flag_check(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic main_bus_cycle(input bus_cmd_t c, output logic [7:0] rd);
		int t;
		@(negedge MCLK);
		main_cmd = c;
		main_req = 1'b1;
		t = 0;
		while (main_ack !== 1'b1) begin
			@(negedge MCLK);
			t++;
			if (t > ACK_TIMEOUT) begin
				$display("Timeout, the main port never raised ack");
				stop_run();
			end
		end
		rd = main_rdata;
		main_req = 1'b0;
		t = 0;
		while (main_ack !== 1'b0) begin
			@(negedge MCLK);
			t++;
			if (t > ACK_TIMEOUT) begin
				$display("Timeout, the main port never dropped ack");
				stop_run();
			end
		end
	endtask

	task automatic sub_bus_cycle(input bus_cmd_t c, output logic [7:0] rd);
		int t;
		@(negedge MCLK);
		sub_cmd = c;
		sub_req = 1'b1;
		t = 0;
		while (sub_ack !== 1'b1) begin
			@(negedge MCLK);
			t++;
			if (t > ACK_TIMEOUT) begin
				$display("Timeout, the sub port never raised ack");
				stop_run();
			end
		end
		rd = sub_rdata;
		sub_req = 1'b0;
		t = 0;
		while (sub_ack !== 1'b0) begin
			@(negedge MCLK);
			t++;
			if (t > ACK_TIMEOUT) begin
				$display("Timeout, the sub port never dropped ack");
				stop_run();
			end
		end
	endtask

	task automatic push_entry(input logic side, input logic [15:0] addr, input logic we,
			input logic [7:0] wdata, input logic [7:0] exp_rd);
		entry_t e;
		e.side = side;
		e.cmd.addr.raw = addr;
		e.cmd.we = we;
		e.cmd.wdata = wdata;
		e.exp_rd = exp_rd;
		e.exp_ctrl = exp_c;
		table_q.push_back(e);
	endtask

	task automatic build_table();
		exp_c = '0;
		push_entry(MAIN, 16'h0123, 1'b1, 8'h3c, 8'h00); // Low bank
		push_entry(MAIN, 16'h0923, 1'b1, 8'ha5, 8'h00); // High bank at the same offset
		push_entry(MAIN, 16'h07ff, 1'b1, 8'h11, 8'h00);
		push_entry(MAIN, 16'h0fff, 1'b1, 8'h22, 8'h00);
		push_entry(MAIN, 16'h0123, 1'b0, 8'h00, 8'h3c);
		push_entry(MAIN, 16'h0923, 1'b0, 8'h00, 8'ha5);
		push_entry(MAIN, 16'h0fff, 1'b0, 8'h00, 8'h22);
		// Shared RAM both ways
		push_entry(MAIN, 16'h4010, 1'b1, 8'h77, 8'h00);
		push_entry(SUB,  16'h8010, 1'b0, 8'h00, 8'h77);
		push_entry(SUB,  16'h43c5, 1'b1, 8'he1, 8'h00);
		push_entry(MAIN, 16'h43c5, 1'b0, 8'h00, 8'he1);
		push_entry(MAIN, 16'h8123, 1'b0, 8'h00, rom_byte(15'h0123));
		push_entry(MAIN, 16'hfedc, 1'b0, 8'h00, rom_byte(15'h7edc));
		for (int k = 0; k < 6; k++)
			push_entry(MAIN, 16'h4800 + k, 1'b0, 8'h00, inputs[8*k +: 8]);
		push_entry(MAIN, 16'h4806, 1'b0, 8'h00, 8'h00); // Past DSW2
		push_entry(MAIN, 16'h4808, 1'b0, 8'h00, 8'h00);
		push_entry(MAIN, 16'h1000, 1'b0, 8'h00, 8'h00); // Unmapped
		push_entry(MAIN, 16'h2000, 1'b0, 8'h00, 8'h00);
		push_entry(SUB,  16'he123, 1'b0, 8'h00, 8'h00); // No ROM on the sub side
		exp_c.scroll = 8'h5a; // Bits 10-3 of $3ad0
		push_entry(MAIN, 16'h3ad0, 1'b1, 8'hff, 8'h00);
		exp_c.main_irq_en = 1'b1;
		push_entry(MAIN, 16'h5003, 1'b1, 8'h00, 8'h00);
		exp_c.sub_irq_en = 1'b1;
		push_entry(MAIN, 16'h5001, 1'b1, 8'h00, 8'h00);
		exp_c.snd_en = 1'b1;
		push_entry(SUB,  16'h2007, 1'b1, 8'h00, 8'h00);
		push_entry(SUB,  16'h2002, 1'b1, 8'h00, 8'h00); // Sub CPU cannot clear the main IRQ enable
		exp_c.sub_rst_rel = 1'b1;
		push_entry(MAIN, 16'h500b, 1'b1, 8'h00, 8'h00);
		exp_c.snd_en = 1'b0;
		push_entry(MAIN, 16'h5006, 1'b1, 8'h00, 8'h00);
		push_entry(SUB,  16'h1c15, 1'b1, 8'h9b, 8'h00); // Sound register mirror
	endtask

	task automatic video_fetch(input logic [`VRAM_ADDR_W-1:0] a, output logic [15:0] d);
		@(negedge MCLK);
		video_rd.addr = a;
		@(negedge MCLK); // One cycle read latency
		d = video_data;
	endtask

	initial begin
		entry_t      e;
		bus_cmd_t    cm;
		bus_cmd_t    cs;
		logic [7:0]  rd;
		logic [7:0]  rd2;
		logic [15:0] vw;
		logic [31:0] rnd;
		void'($urandom(32'h55a3));
		rnd = $urandom;
		inputs[31:0] = rnd;
		rnd = $urandom;
		inputs[47:32] = rnd[15:0];
		RESET = 1'b1;
		main_req = 1'b0;
		sub_req = 1'b0;
		main_cmd = '0;
		sub_cmd = '0;
		vblank = 1'b1;
		video_rd = '0;
		for (int i = 0; i < 3; i++)
			@(posedge MCLK);
		@(negedge MCLK);
		RESET = 1'b0;

		@(negedge MCLK);
		match_ctrl(ctrl, '0, "after reset");
		flag_check(sub_cpu_reset, 1'b1, "sub_cpu_reset after reset");
		flag_check(main_irq, 1'b0, "main_irq after reset");
		flag_check(sub_irq, 1'b0, "sub_irq after reset");
		vblank = 1'b0;

		build_table();
		foreach (table_q[i]) begin
			e = table_q[i];
			if (e.side == MAIN)
				main_bus_cycle(e.cmd, rd);
			else
				sub_bus_cycle(e.cmd, rd);
			if (!e.cmd.we)
				expect_byte(rd, e.exp_rd, $sformatf("entry %0d read %04h", i, e.cmd.addr.raw));
			match_ctrl(ctrl, e.exp_ctrl, $sformatf("entry %0d", i));
		end
		flag_check(sub_cpu_reset, 1'b0, "sub_cpu_reset after release");

		// High bank in the upper byte
		video_fetch(11'h123, vw);
		video_word_check(vw, 16'ha53c, 11'h123);
		video_fetch(11'h7ff, vw);
		video_word_check(vw, 16'h2211, 11'h7ff);

		sound_pulse_check(snd_pulses, snd_addr_seen, snd_data_seen, 1, 6'h15, 8'h9b);

		flag_check(main_irq, 1'b0, "main_irq outside vblank");
		flag_check(sub_irq, 1'b0, "sub_irq outside vblank");
		@(negedge MCLK);
		vblank = 1'b1;
		@(negedge MCLK);
		flag_check(main_irq, 1'b1, "main_irq in vblank");
		flag_check(sub_irq, 1'b1, "sub_irq in vblank");

		// Both CPUs write the sub IRQ enable in the same cycle
		cm.addr.raw = 16'h5001;
		cm.we = 1'b1;
		cm.wdata = 8'h00;
		cs.addr.raw = 16'h2000;
		cs.we = 1'b1;
		cs.wdata = 8'h00;
		exp_c.sub_irq_en = 1'b0;
		fork
			main_bus_cycle(cm, rd);
			sub_bus_cycle(cs, rd2);
		join
		match_ctrl(ctrl, exp_c, "same-cycle latch write");
		flag_check(main_irq, 1'b1, "main_irq after clash");
		flag_check(sub_irq, 1'b0, "sub_irq after clash");

		if (uut.chk.fail_cnt == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/druaga_bus_pkg.sv
logic/bus_port.sv
logic/main_map_decode.sv
logic/sub_map_decode.sv
logic/dual_port_ram.sv
logic/ctrl_regs.sv
logic/druaga_bus_core.sv
testbench/druaga_bus_chk.sv
testbench/tb_druaga_bus.sv
